// File: filelist.f
source/mem_pkg.sv
source/bank_router.sv
source/burst_bank.sv
source/read_merger.sv
source/mem_subsystem.sv
dv/clock_gen.sv
dv/mem_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module mem_subsystem_tb \
  --Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi

exit 0

// File: dv/mem_subsystem_tb.sv
`default_nettype none

module mem_subsystem_tb;

  typedef enum int {
    OP_WRITE,
    OP_READ,
    OP_WRITE_BUSY
  } op_t;

  localparam int row_count      = 26;
  localparam int reset_cycles   = 10;
  localparam int timeout_cycles = row_count * 10 + reset_cycles;
  localparam int model_words    = mem_pkg::bank_count * mem_pkg::bank_words;

  logic                                clock;
  logic                                reset_n;
  logic [mem_pkg::addr_width-1:0]      addr;
  logic [mem_pkg::burst_len_width-1:0] burst_len;
  logic [mem_pkg::data_width-1:0]      data_in;
  logic                                wr;
  logic                                rd;
  logic                                waitrequest;
  logic [mem_pkg::data_width-1:0]      data_out;
  logic                                rd_valid;

  op_t                                 op_tab   [row_count];
  int                                  bank_tab [row_count];
  int                                  word_tab [row_count];
  logic [mem_pkg::burst_len_width-1:0] len_tab  [row_count];
  logic                                wait_tab [row_count]; // waitrequest in the first cycle.
  logic [mem_pkg::data_width-1:0]      data_tab [row_count];

  logic [mem_pkg::data_width-1:0] model_mem [model_words];
  logic [mem_pkg::data_width-1:0] exp_q [$];
  int                             row_fill       = 0;
  int                             exp_beats      = 0;
  int                             beat_count     = 0;
  int                             mismatch_count = 0;
  int                             other_count    = 0;

  clock_gen clock_gen_inst (
    .clock (clock)
  );

  mem_subsystem mem_subsystem_inst (
    .clock       (clock),
    .reset_n     (reset_n),
    .addr        (addr),
    .burst_len   (burst_len),
    .data_in     (data_in),
    .wr          (wr),
    .rd          (rd),
    .waitrequest (waitrequest),
    .data_out    (data_out),
    .rd_valid    (rd_valid)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at time %0t",
               name, actual, expected, $time);
    end
  endtask

  function automatic logic [mem_pkg::addr_width-1:0] byte_addr(input int bank, input int word);
    int value;
    value = (bank << (mem_pkg::byte_shift + mem_pkg::bank_addr_width)) |
            (word << mem_pkg::byte_shift);
    return value[mem_pkg::addr_width-1:0];
  endfunction

  task automatic add_row(input op_t op, input int bank, input int word, input int len,
                         input logic exp_wait);
    op_tab[row_fill]   = op;
    bank_tab[row_fill] = bank;
    word_tab[row_fill] = word;
    len_tab[row_fill]  = len[mem_pkg::burst_len_width-1:0];
    wait_tab[row_fill] = exp_wait;
    data_tab[row_fill] = (op == OP_READ) ? 32'd0 : $urandom();
    if (op == OP_READ)
      exp_beats += (len == 2) ? 4 : len + 1;
    row_fill++;
  endtask

  task automatic fill_table();
    add_row(OP_WRITE,      0,  5, 0, 1'b0); // one word in every bank.
    add_row(OP_WRITE,      1,  5, 0, 1'b0);
    add_row(OP_WRITE,      2,  5, 0, 1'b0);
    add_row(OP_WRITE,      3,  5, 0, 1'b0);
    add_row(OP_READ,       0,  5, 0, 1'b0); // each single beat read waits for the one before.
    add_row(OP_READ,       1,  5, 0, 1'b1);
    add_row(OP_READ,       2,  5, 0, 1'b1);
    add_row(OP_READ,       3,  5, 0, 1'b1);
    add_row(OP_WRITE,      1,  8, 0, 1'b0);
    add_row(OP_WRITE,      1,  9, 0, 1'b0);
    add_row(OP_READ,       1,  9, 1, 1'b0); // odd start wraps to the even word.
    add_row(OP_WRITE,      2, 16, 0, 1'b0);
    add_row(OP_WRITE,      2, 17, 0, 1'b0);
    add_row(OP_WRITE,      2, 18, 0, 1'b0);
    add_row(OP_WRITE,      2, 19, 0, 1'b0);
    add_row(OP_READ,       2, 18, 3, 1'b0); // offsets 2, 3, 0, 1.
    add_row(OP_READ,       2, 18, 2, 1'b1); // code 2 runs as code 3.
    add_row(OP_READ,       2, 17, 3, 1'b1);
    add_row(OP_WRITE_BUSY, 3, 40, 0, 1'b0); // other bank goes through.
    add_row(OP_WRITE_BUSY, 2, 20, 0, 1'b1); // bursting bank stalls it.
    add_row(OP_READ,       3, 40, 0, 1'b0);
    add_row(OP_READ,       2, 20, 0, 1'b1);
    add_row(OP_READ,       1,  8, 1, 1'b1);
    add_row(OP_READ,       2, 19, 3, 1'b1);
    add_row(OP_READ,       0,  5, 0, 1'b1);
    add_row(OP_READ,       3,  5, 0, 1'b1);
  endtask

  // Expected beats step upward and wrap inside the aligned block of L+1 words.
  task automatic model_accept(input int row);
    int windex;
    int len_eff;
    int base;
    int off;
    windex = bank_tab[row] * mem_pkg::bank_words + word_tab[row];
    if (op_tab[row] == OP_READ) begin
      len_eff = (len_tab[row] == 2'd2) ? 3 : int'(len_tab[row]);
      base    = windex & ~len_eff;
      off     = windex & len_eff;
      for (int k = 0; k <= len_eff; k++) begin
        exp_q.push_back(model_mem[base | ((off + k) & len_eff)]);
      end
    end else begin
      model_mem[windex] = data_tab[row];
    end
  endtask

  // called on a rising edge and returns on the edge that accepts the request.
  task automatic apply_row(input int row);
    logic first;
    logic accepted;
    first    = 1'b1;
    accepted = 1'b0;
    addr      <= byte_addr(bank_tab[row], word_tab[row]);
    burst_len <= len_tab[row];
    data_in   <= data_tab[row];
    wr        <= (op_tab[row] != OP_READ);
    rd        <= (op_tab[row] == OP_READ);
    while (!accepted) begin
      @(negedge clock);
      if (first) begin
        check_value("waitrequest", 32'(waitrequest), 32'(wait_tab[row]));
        first = 1'b0;
      end
      accepted = !waitrequest;
    end
    model_accept(row);
    @(posedge clock);
  endtask

  always @(negedge clock) begin
    if (reset_n && rd_valid) begin
      if (exp_q.size() == 0) begin
        other_count++;
        $display("A read beat arrived with no read outstanding at time %0t", $time);
      end else begin
        check_value("data_out", data_out, exp_q.pop_front());
      end
      beat_count++;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clock);
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    reset_n   = 1'b0;
    addr      = '0;
    burst_len = '0;
    data_in   = '0;
    wr        = 1'b0;
    rd        = 1'b0;
    void'($urandom(32'hf44d_6ea1));
    fill_table();
    repeat (reset_cycles) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    check_value("rd_valid", 32'(rd_valid), 32'd0);
    check_value("waitrequest", 32'(waitrequest), 32'd0);
    @(posedge clock);
    for (int i = 0; i < row_count; i++) begin
      apply_row(i);
    end
    wr <= 1'b0;
    rd <= 1'b0;
    while (exp_q.size() != 0) @(negedge clock);
    repeat (4) @(negedge clock); // catch any stray beats.
    check_value("beat_count", 32'(beat_count), 32'(exp_beats));
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/clock_gen.sv
`default_nettype none

module clock_gen (
  output logic clock
);

  localparam int half_period = 20; // 40 time units per cycle.

  initial begin
    clock = 1'b0;
    forever begin
      #half_period clock = ~clock;
    end
  end

endmodule

`default_nettype wire

// File: source/mem_subsystem.sv
`default_nettype none

module mem_subsystem (
  input  wire logic                                clock,
  input  wire logic                                reset_n,
  input  wire logic [mem_pkg::addr_width-1:0]      addr,
  input  wire logic [mem_pkg::burst_len_width-1:0] burst_len,
  input  wire logic [mem_pkg::data_width-1:0]      data_in,
  input  wire logic                                wr,
  input  wire logic                                rd,
  output logic                                     waitrequest,
  output logic [mem_pkg::data_width-1:0]           data_out,
  output logic                                     rd_valid
);

  logic [mem_pkg::bank_count-1:0]      bank_wr;
  logic [mem_pkg::bank_count-1:0]      bank_rd;
  logic [mem_pkg::bank_count-1:0]      bank_busy;
  logic [mem_pkg::bank_count-1:0]      beat_valid;
  logic [mem_pkg::bank_addr_width-1:0] word_addr;
  logic [mem_pkg::burst_len_width-1:0] bank_len;
  logic [mem_pkg::data_width-1:0]      bank_data;
  logic [mem_pkg::data_width-1:0]      beat_data [mem_pkg::bank_count];

  bank_router bank_router_inst (
    .addr        (addr),
    .burst_len   (burst_len),
    .data_in     (data_in),
    .wr          (wr),
    .rd          (rd),
    .bank_busy   (bank_busy),
    .waitrequest (waitrequest),
    .bank_wr     (bank_wr),
    .bank_rd     (bank_rd),
    .word_addr   (word_addr),
    .bank_len    (bank_len),
    .bank_data   (bank_data)
  );

  // address, length and write data are shared, only the strobes are per bank.
  for (genvar g = 0; g < mem_pkg::bank_count; g++) begin : gen_bank
    burst_bank burst_bank_inst (
      .clock      (clock),
      .reset_n    (reset_n),
      .wr         (bank_wr[g]),
      .rd         (bank_rd[g]),
      .word_addr  (word_addr),
      .burst_len  (bank_len),
      .data_in    (bank_data),
      .busy       (bank_busy[g]),
      .beat_valid (beat_valid[g]),
      .beat_data  (beat_data[g])
    );
  end

  read_merger read_merger_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .rd_valid   (rd_valid),
    .data_out   (data_out)
  );

endmodule

`default_nettype wire

// File: source/read_merger.sv
`default_nettype none

module read_merger (
  input  wire logic                           clock,
  input  wire logic                           reset_n,
  input  wire logic [mem_pkg::bank_count-1:0] beat_valid,
  input  wire logic [mem_pkg::data_width-1:0] beat_data [mem_pkg::bank_count],
  output logic                                rd_valid,
  output logic [mem_pkg::data_width-1:0]      data_out
);

  logic [mem_pkg::data_width-1:0] sel_data;
  logic                           any_valid;

  assign any_valid = |beat_valid;

  // at most one bank presents a beat, so the first valid one is the only one.
  always_comb begin
    sel_data = '0;
    for (int i = mem_pkg::bank_count - 1; i >= 0; i--) begin
      if (beat_valid[i])
        sel_data = beat_data[i];
    end
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      rd_valid <= 1'b0;
      data_out <= '0;
    end else begin
      rd_valid <= any_valid;
      if (any_valid)
        data_out <= sel_data; // holds the last beat between bursts.
    end
  end

endmodule

`default_nettype wire

// File: source/burst_bank.sv
`default_nettype none

module burst_bank (
  input  wire logic                                clock,
  input  wire logic                                reset_n,
  input  wire logic                                wr,
  input  wire logic                                rd,
  input  wire logic [mem_pkg::bank_addr_width-1:0] word_addr,
  input  wire logic [mem_pkg::burst_len_width-1:0] burst_len,
  input  wire logic [mem_pkg::data_width-1:0]      data_in,
  output logic                                     busy,
  output logic                                     beat_valid,
  output logic [mem_pkg::data_width-1:0]           beat_data
);

  mem_pkg::bank_state_t state;
  mem_pkg::bank_state_t next_state;

  logic [mem_pkg::data_width-1:0]      mem [mem_pkg::bank_words];
  logic [mem_pkg::burst_len_width-1:0] count_r;
  logic [mem_pkg::burst_len_width-1:0] len_r;
  logic [mem_pkg::bank_addr_width-1:0] burst_addr;
  logic [mem_pkg::bank_addr_width-1:0] wrap_mask;
  logic                                start;

  assign busy  = (state == mem_pkg::BANK_BURST);
  assign start = (state == mem_pkg::BANK_IDLE) && rd;

  // the low address bits covered by the burst length form the wrap window.
  assign wrap_mask = {{(mem_pkg::bank_addr_width - mem_pkg::burst_len_width){1'b0}}, len_r};

  always_comb begin
    next_state = state;
    case (state)
      mem_pkg::BANK_IDLE: begin
        if (rd)
          next_state = mem_pkg::BANK_BURST;
      end
      mem_pkg::BANK_BURST: begin
        if (count_r == '0)
          next_state = mem_pkg::BANK_IDLE; // last beat leaves on this edge.
      end
      default: next_state = mem_pkg::BANK_IDLE;
    endcase
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n)
      state <= mem_pkg::BANK_IDLE;
    else
      state <= next_state;
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n) begin
      count_r    <= '0;
      len_r      <= '0;
      burst_addr <= '0;
    end else if (start) begin
      count_r    <= burst_len;
      len_r      <= burst_len;
      burst_addr <= word_addr;
    end else if (busy) begin
      if (count_r != '0)
        count_r <= count_r - 1'b1;
      if ((burst_addr & wrap_mask) == wrap_mask)
        burst_addr <= burst_addr & ~wrap_mask; // back to the start of the block.
      else
        burst_addr <= burst_addr + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr)
      mem[word_addr] <= data_in;
  end

  // one beat leaves the array in every burst cycle.
  always_ff @(posedge clock) begin
    if (busy)
      beat_data <= mem[burst_addr];
  end

  always_ff @(posedge clock, negedge reset_n) begin
    if (!reset_n)
      beat_valid <= 1'b0;
    else
      beat_valid <= busy;
  end

endmodule

`default_nettype wire

// File: source/bank_router.sv
`default_nettype none

module bank_router (
  input  wire logic [mem_pkg::addr_width-1:0]      addr,
  input  wire logic [mem_pkg::burst_len_width-1:0] burst_len,
  input  wire logic [mem_pkg::data_width-1:0]      data_in,
  input  wire logic                                wr,
  input  wire logic                                rd,
  input  wire logic [mem_pkg::bank_count-1:0]      bank_busy,
  output logic                                     waitrequest,
  output logic [mem_pkg::bank_count-1:0]           bank_wr,
  output logic [mem_pkg::bank_count-1:0]           bank_rd,
  output logic [mem_pkg::bank_addr_width-1:0]      word_addr,
  output logic [mem_pkg::burst_len_width-1:0]      bank_len,
  output logic [mem_pkg::data_width-1:0]           bank_data
);

  logic [mem_pkg::bank_sel_width-1:0] bank_sel;
  logic [mem_pkg::bank_count-1:0]     sel_onehot;
  logic                               sel_busy;
  logic                               any_busy;
  logic                               request;
  logic                               accept;

  // the bank index sits directly above the in-bank word address.
  assign word_addr = addr[mem_pkg::byte_shift +: mem_pkg::bank_addr_width];
  assign bank_sel  = addr[mem_pkg::byte_shift + mem_pkg::bank_addr_width +:
                          mem_pkg::bank_sel_width];

  // a code of 2 is not a power-of-two block, so it runs as a four beat burst.
  assign bank_len  = (burst_len == 2'd2) ? 2'd3 : burst_len;
  assign bank_data = data_in;

  always_comb begin
    sel_onehot = '0;
    sel_onehot[bank_sel] = 1'b1;
  end

  assign sel_busy = |(bank_busy & sel_onehot);
  assign any_busy = |bank_busy;
  assign request  = wr | rd;

  // Reads wait for every bank so that only one burst is ever in flight.
  assign waitrequest = request & (sel_busy | (rd & any_busy));
  assign accept      = request & ~waitrequest;

  assign bank_wr = (accept & wr) ? sel_onehot : '0; // one strobe per accepted write.
  assign bank_rd = (accept & rd) ? sel_onehot : '0;

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // request side sizes.
  localparam int addr_width      = 16;
  localparam int data_width      = 32;
  localparam int burst_len_width = 2;

  // bank organisation.
  localparam int bank_count      = 4;
  localparam int bank_sel_width  = $clog2(bank_count);
  localparam int bank_words      = 1024;
  localparam int bank_addr_width = $clog2(bank_words);

  // byte address to word address.
  localparam int byte_shift      = $clog2(data_width / 8);

  // bank controller states.
  typedef enum logic [0:0] {
    BANK_IDLE,
    BANK_BURST
  } bank_state_t;

endpackage

`default_nettype wire
